//--- build.f
hw/mips_pkg.sv
hw/exe_op_if.sv
hw/unit_result_if.sv
hw/regfile.sv
hw/id_stage.sv
hw/alu_unit.sv
hw/hilo_unit.sv
hw/wb_stage.sv
hw/mini_mips_core.sv
test/mini_mips_core_sva.sv
test/tb_mini_mips_core.sv

//--- hw/alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
    input  logic           cpu_clk_50M,
    input  logic           rst_i,
    exe_op_if.exec         op_i,
    unit_result_if.produce res_o
);

    logic            own_op;
    logic            slt;
    mips_pkg::word_t result;

    assign slt = ($signed(op_i.src1) < $signed(op_i.src2));

    always_comb begin
        own_op = 1'b1;
        result = '0;
        case (op_i.op)
            mips_pkg::EXE_NOP:  result = '0;
            mips_pkg::EXE_ADDU: result = op_i.src1 + op_i.src2;
            mips_pkg::EXE_SUBU: result = op_i.src1 - op_i.src2;
            mips_pkg::EXE_AND:  result = op_i.src1 & op_i.src2;
            mips_pkg::EXE_OR:   result = op_i.src1 | op_i.src2;
            mips_pkg::EXE_XOR:  result = op_i.src1 ^ op_i.src2;
            mips_pkg::EXE_SLT:  result = {{(mips_pkg::WORD_W-1){1'b0}}, slt};
            // shift amount rides in src1
            mips_pkg::EXE_SLL:  result = op_i.src2 << op_i.src1[mips_pkg::SHAMT_W-1:0];
            mips_pkg::EXE_LUI:  result = {op_i.src2[mips_pkg::IMM_W-1:0],
                                          {(mips_pkg::WORD_W - mips_pkg::IMM_W){1'b0}}};
            default:            own_op = 1'b0;
        endcase
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (rst_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= op_i.valid && own_op;
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        res_o.wreg <= op_i.wreg;
        res_o.wa   <= op_i.wa;
        res_o.wd   <= result;
        res_o.pc   <= op_i.pc;
    end

endmodule

//--- hw/exe_op_if.sv
`timescale 1ns/100ps

// decoded op with final operand values, shared by both execute units
interface exe_op_if;

    logic                valid;
    mips_pkg::exe_op_e   op;
    mips_pkg::word_t     src1;
    mips_pkg::word_t     src2;
    mips_pkg::reg_addr_t wa;
    logic                wreg;
    mips_pkg::word_t     pc;

    // decode side
    modport issue (output valid, op, src1, src2, wa, wreg, pc);

    // each unit picks out its own op class
    modport exec (input valid, op, src1, src2, wa, wreg, pc);

endinterface

//--- hw/hilo_unit.sv
`timescale 1ns/100ps

module hilo_unit (
    input  logic           cpu_clk_50M,
    input  logic           rst_i,
    exe_op_if.exec         op_i,
    unit_result_if.produce res_o
);

    mips_pkg::word_t  hi_q;
    mips_pkg::word_t  lo_q;
    logic             own_op;
    logic             sign_ext;
    mips_pkg::dword_t prod;

    assign own_op = op_i.op inside {mips_pkg::EXE_MULT, mips_pkg::EXE_MULTU,
                                    mips_pkg::EXE_MFHI, mips_pkg::EXE_MFLO,
                                    mips_pkg::EXE_MTHI, mips_pkg::EXE_MTLO};

    // one 64-bit multiplier, operands extended by sign for MULT
    assign sign_ext = (op_i.op == mips_pkg::EXE_MULT);
    assign prod = {{mips_pkg::WORD_W{sign_ext & op_i.src1[mips_pkg::WORD_W-1]}}, op_i.src1} *
                  {{mips_pkg::WORD_W{sign_ext & op_i.src2[mips_pkg::WORD_W-1]}}, op_i.src2};

    always_ff @(posedge cpu_clk_50M) begin
        if (rst_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (op_i.valid) begin
            case (op_i.op)
                mips_pkg::EXE_MULT, mips_pkg::EXE_MULTU: begin
                    hi_q <= prod[2*mips_pkg::WORD_W-1:mips_pkg::WORD_W];
                    lo_q <= prod[mips_pkg::WORD_W-1:0];
                end
                mips_pkg::EXE_MTHI: hi_q <= op_i.src1;
                mips_pkg::EXE_MTLO: lo_q <= op_i.src1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (rst_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= op_i.valid && own_op;
        end
    end

    // only MFHI and MFLO carry wreg, wd is don't-care otherwise
    always_ff @(posedge cpu_clk_50M) begin
        res_o.wreg <= op_i.wreg;
        res_o.wa   <= op_i.wa;
        res_o.wd   <= (op_i.op == mips_pkg::EXE_MFHI) ? hi_q : lo_q;
        res_o.pc   <= op_i.pc;
    end

endmodule

//--- hw/id_stage.sv
`timescale 1ns/100ps

module id_stage (
    input  logic                cpu_clk_50M,
    input  logic                rst_i,
    input  logic                inst_valid_i,
    input  mips_pkg::word_t     inst_i,
    input  mips_pkg::word_t     inst_pc_i,
    input  mips_pkg::word_t     rd1_i,
    input  mips_pkg::word_t     rd2_i,
    output mips_pkg::reg_addr_t ra1_o,
    output mips_pkg::reg_addr_t ra2_o,
    unit_result_if.snoop        alu_res,
    unit_result_if.snoop        hilo_res,
    input  logic                wb_we_i,
    input  mips_pkg::reg_addr_t wb_wa_i,
    input  mips_pkg::word_t     wb_wd_i,
    exe_op_if.issue             op_o
);

    logic [5:0]          opcode;
    logic [5:0]          funct;
    logic                is_special;
    mips_pkg::exe_op_e   special_op;
    mips_pkg::exe_op_e   dec_op;
    mips_pkg::reg_addr_t dec_wa;
    logic                dec_wreg;
    mips_pkg::word_t     dec_imm;

    logic                valid_q;
    mips_pkg::exe_op_e   op_q;
    mips_pkg::reg_addr_t wa_q;
    logic                wreg_q;
    mips_pkg::word_t     pc_q;
    mips_pkg::word_t     imm_q;
    logic                imm1_q;
    logic                imm2_q;
    mips_pkg::reg_addr_t rs_q;
    mips_pkg::reg_addr_t rt_q;
    mips_pkg::word_t     raw1_q;
    mips_pkg::word_t     raw2_q;
    mips_pkg::word_t     src1;
    mips_pkg::word_t     src2;

    assign opcode     = inst_i[31:26];
    assign funct      = inst_i[5:0];
    assign is_special = (opcode == mips_pkg::OP_SPECIAL);
    assign ra1_o      = inst_i[25:21];
    assign ra2_o      = inst_i[20:16];

    always_comb begin
        case (funct)
            mips_pkg::FN_ADDU:  special_op = mips_pkg::EXE_ADDU;
            mips_pkg::FN_SUBU:  special_op = mips_pkg::EXE_SUBU;
            mips_pkg::FN_AND:   special_op = mips_pkg::EXE_AND;
            mips_pkg::FN_OR:    special_op = mips_pkg::EXE_OR;
            mips_pkg::FN_XOR:   special_op = mips_pkg::EXE_XOR;
            mips_pkg::FN_SLT:   special_op = mips_pkg::EXE_SLT;
            mips_pkg::FN_SLL:   special_op = mips_pkg::EXE_SLL;
            mips_pkg::FN_MULT:  special_op = mips_pkg::EXE_MULT;
            mips_pkg::FN_MULTU: special_op = mips_pkg::EXE_MULTU;
            mips_pkg::FN_MFHI:  special_op = mips_pkg::EXE_MFHI;
            mips_pkg::FN_MFLO:  special_op = mips_pkg::EXE_MFLO;
            mips_pkg::FN_MTHI:  special_op = mips_pkg::EXE_MTHI;
            mips_pkg::FN_MTLO:  special_op = mips_pkg::EXE_MTLO;
            default:            special_op = mips_pkg::EXE_NOP;
        endcase
    end

    // anything not listed falls through as NOP
    always_comb begin
        case (opcode)
            mips_pkg::OP_SPECIAL: dec_op = special_op;
            mips_pkg::OP_ADDIU:   dec_op = mips_pkg::EXE_ADDU;
            mips_pkg::OP_ORI:     dec_op = mips_pkg::EXE_OR;
            mips_pkg::OP_LUI:     dec_op = mips_pkg::EXE_LUI;
            default:              dec_op = mips_pkg::EXE_NOP;
        endcase
    end

    assign dec_wa = is_special ? inst_i[15:11] : inst_i[20:16];

    // no GPR write for these, nor for $0
    always_comb begin
        case (dec_op)
            mips_pkg::EXE_NOP, mips_pkg::EXE_MULT, mips_pkg::EXE_MULTU,
            mips_pkg::EXE_MTHI, mips_pkg::EXE_MTLO: dec_wreg = 1'b0;
            default:                                dec_wreg = (dec_wa != '0);
        endcase
    end

    // shamt for SLL, sign extended for ADDIU, zero extended otherwise
    always_comb begin
        if (is_special) begin
            dec_imm = {{(mips_pkg::WORD_W - mips_pkg::SHAMT_W){1'b0}},
                       inst_i[6 +: mips_pkg::SHAMT_W]};
        end else if (opcode == mips_pkg::OP_ADDIU) begin
            dec_imm = {{(mips_pkg::WORD_W - mips_pkg::IMM_W){inst_i[mips_pkg::IMM_W-1]}},
                       inst_i[mips_pkg::IMM_W-1:0]};
        end else begin
            dec_imm = {{(mips_pkg::WORD_W - mips_pkg::IMM_W){1'b0}},
                       inst_i[mips_pkg::IMM_W-1:0]};
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge cpu_clk_50M) begin
        op_q   <= dec_op;
        wa_q   <= dec_wa;
        wreg_q <= dec_wreg;
        pc_q   <= inst_pc_i;
        imm_q  <= dec_imm;
        imm1_q <= (dec_op == mips_pkg::EXE_SLL);
        imm2_q <= !is_special;
        rs_q   <= ra1_o;
        rt_q   <= ra2_o;
        raw1_q <= rd1_i;
        raw2_q <= rd2_i;
    end

    // youngest writer wins: unit results, then writeback, then the raw read
    function automatic mips_pkg::word_t fwd_src(input mips_pkg::reg_addr_t ra,
                                                input mips_pkg::word_t raw);
        mips_pkg::word_t val;
        val = raw;
        if (wb_we_i && (wb_wa_i == ra)) begin
            val = wb_wd_i;
        end
        if (hilo_res.valid && hilo_res.wreg && (hilo_res.wa == ra)) begin
            val = hilo_res.wd;
        end
        if (alu_res.valid && alu_res.wreg && (alu_res.wa == ra)) begin
            val = alu_res.wd;
        end
        return val;
    endfunction

    always_comb begin
        src1 = imm1_q ? imm_q : fwd_src(rs_q, raw1_q);
        src2 = imm2_q ? imm_q : fwd_src(rt_q, raw2_q);
    end

    assign op_o.valid = valid_q;
    assign op_o.op    = op_q;
    assign op_o.src1  = src1;
    assign op_o.src2  = src2;
    assign op_o.wa    = wa_q;
    assign op_o.wreg  = wreg_q;
    assign op_o.pc    = pc_q;

endmodule

//--- hw/mini_mips_core.sv
`timescale 1ns/100ps

module mini_mips_core (
    input  logic                             cpu_clk_50M,
    input  logic                             rst_i,
    input  logic                             inst_valid_i,
    input  mips_pkg::word_t                  inst_i,
    input  mips_pkg::word_t                  inst_pc_i,
    output mips_pkg::word_t                  debug_wb_pc_o,
    output logic [mips_pkg::DEBUG_WEN_W-1:0] debug_wb_rf_wen_o,
    output mips_pkg::reg_addr_t              debug_wb_rf_wnum_o,
    output mips_pkg::word_t                  debug_wb_rf_wdata_o
);

    logic                rf_we;
    mips_pkg::reg_addr_t ra1;
    mips_pkg::reg_addr_t ra2;
    mips_pkg::word_t     rd1;
    mips_pkg::word_t     rd2;

    exe_op_if      exe_op ();
    unit_result_if alu_res ();
    unit_result_if hilo_res ();

    id_stage u_id_stage (
        .cpu_clk_50M (cpu_clk_50M),
        .rst_i       (rst_i),
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .inst_pc_i   (inst_pc_i),
        .rd1_i       (rd1),
        .rd2_i       (rd2),
        .ra1_o       (ra1),
        .ra2_o       (ra2),
        .alu_res     (alu_res),
        .hilo_res    (hilo_res),
        .wb_we_i     (rf_we),
        .wb_wa_i     (debug_wb_rf_wnum_o),
        .wb_wd_i     (debug_wb_rf_wdata_o),
        .op_o        (exe_op)
    );

    // writeback register feeds the register file and the debug port directly
    regfile u_regfile (
        .cpu_clk_50M(cpu_clk_50M),
        .rst_i      (rst_i),
        .we_i       (rf_we),
        .wa_i       (debug_wb_rf_wnum_o),
        .wd_i       (debug_wb_rf_wdata_o),
        .ra1_i      (ra1),
        .ra2_i      (ra2),
        .rd1_o      (rd1),
        .rd2_o      (rd2)
    );

    alu_unit u_alu_unit (
        .cpu_clk_50M(cpu_clk_50M),
        .rst_i      (rst_i),
        .op_i       (exe_op),
        .res_o      (alu_res)
    );

    hilo_unit u_hilo_unit (
        .cpu_clk_50M(cpu_clk_50M),
        .rst_i      (rst_i),
        .op_i       (exe_op),
        .res_o      (hilo_res)
    );

    wb_stage u_wb_stage (
        .cpu_clk_50M(cpu_clk_50M),
        .rst_i      (rst_i),
        .alu_res    (alu_res),
        .hilo_res   (hilo_res),
        .we_o       (rf_we),
        .wa_o       (debug_wb_rf_wnum_o),
        .wd_o       (debug_wb_rf_wdata_o),
        .pc_o       (debug_wb_pc_o),
        .rf_wen_o   (debug_wb_rf_wen_o)
    );

endmodule

//--- hw/mips_pkg.sv
package mips_pkg;

    localparam int WORD_W      = 32;
    localparam int REG_NUM     = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DEBUG_WEN_W = 4;
    localparam int IMM_W       = 16;
    localparam int SHAMT_W     = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [2*WORD_W-1:0]   dword_t;

    // ADDIU issues as ADDU and ORI as OR, immediate in src2
    typedef enum logic [4:0] {
        EXE_NOP,
        EXE_ADDU,
        EXE_SUBU,
        EXE_AND,
        EXE_OR,
        EXE_XOR,
        EXE_SLT,
        EXE_SLL,
        EXE_LUI,
        EXE_MULT,
        EXE_MULTU,
        EXE_MFHI,
        EXE_MFLO,
        EXE_MTHI,
        EXE_MTLO
    } exe_op_e;

    // primary opcode
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // funct field under SPECIAL
    localparam logic [5:0] FN_SLL   = 6'b000000;
    localparam logic [5:0] FN_MFHI  = 6'b010000;
    localparam logic [5:0] FN_MTHI  = 6'b010001;
    localparam logic [5:0] FN_MFLO  = 6'b010010;
    localparam logic [5:0] FN_MTLO  = 6'b010011;
    localparam logic [5:0] FN_MULT  = 6'b011000;
    localparam logic [5:0] FN_MULTU = 6'b011001;
    localparam logic [5:0] FN_ADDU  = 6'b100001;
    localparam logic [5:0] FN_SUBU  = 6'b100011;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_XOR   = 6'b100110;
    localparam logic [5:0] FN_SLT   = 6'b101010;

endpackage

//--- hw/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic                cpu_clk_50M,
    input  logic                rst_i,
    input  logic                we_i,
    input  mips_pkg::reg_addr_t wa_i,
    input  mips_pkg::word_t     wd_i,
    input  mips_pkg::reg_addr_t ra1_i,
    input  mips_pkg::reg_addr_t ra2_i,
    output mips_pkg::word_t     rd1_o,
    output mips_pkg::word_t     rd2_o
);

    mips_pkg::word_t regs [mips_pkg::REG_NUM];

    // $0 reads zero, same-cycle write passes straight through
    function automatic mips_pkg::word_t read_port(input mips_pkg::reg_addr_t ra);
        if (ra == '0) begin
            return '0;
        end else if (we_i && (wa_i == ra)) begin
            return wd_i;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge cpu_clk_50M) begin
        if (rst_i) begin
            for (int i = 0; i < mips_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    always_comb begin
        rd1_o = read_port(ra1_i);
        rd2_o = read_port(ra2_i);
    end

endmodule

//--- hw/unit_result_if.sv
`timescale 1ns/100ps

interface unit_result_if;

    logic                valid;
    logic                wreg;
    mips_pkg::reg_addr_t wa;
    mips_pkg::word_t     wd;
    mips_pkg::word_t     pc;

    modport produce (output valid, wreg, wa, wd, pc);

    modport consume (input valid, wreg, wa, wd, pc);

    // forwarding tap into decode, pc not needed there
    modport snoop (input valid, wreg, wa, wd);

endinterface

//--- hw/wb_stage.sv
`timescale 1ns/100ps

module wb_stage (
    input  logic                             cpu_clk_50M,
    input  logic                             rst_i,
    unit_result_if.consume                   alu_res,
    unit_result_if.consume                   hilo_res,
    output logic                             we_o,
    output mips_pkg::reg_addr_t              wa_o,
    output mips_pkg::word_t                  wd_o,
    output mips_pkg::word_t                  pc_o,
    output logic [mips_pkg::DEBUG_WEN_W-1:0] rf_wen_o
);

    logic any_valid;
    logic sel_wreg;

    // at most one unit is valid per cycle
    assign any_valid = alu_res.valid || hilo_res.valid;
    assign sel_wreg  = alu_res.valid ? alu_res.wreg : hilo_res.wreg;

    always_ff @(posedge cpu_clk_50M) begin
        if (rst_i) begin
            we_o <= 1'b0;
            wa_o <= '0;
            wd_o <= '0;
            pc_o <= '0;
        end else begin
            we_o <= any_valid && sel_wreg;
            // idle cycles keep the last instruction on the debug port
            if (any_valid) begin
                wa_o <= alu_res.valid ? alu_res.wa : hilo_res.wa;
                wd_o <= alu_res.valid ? alu_res.wd : hilo_res.wd;
                pc_o <= alu_res.valid ? alu_res.pc : hilo_res.pc;
            end
        end
    end

    assign rf_wen_o = {mips_pkg::DEBUG_WEN_W{we_o}};

endmodule

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_mini_mips_core
./obj_dir/Vtb_mini_mips_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "run passed"
else
    echo "run did not pass, see sim.log"
    exit 1
fi

//--- test/mini_mips_core_sva.sv
`timescale 1ns/100ps

module mini_mips_core_sva (
    input logic                             cpu_clk_50M,
    input logic                             rst_i,
    input mips_pkg::word_t                  debug_wb_pc_o,
    input logic [mips_pkg::DEBUG_WEN_W-1:0] debug_wb_rf_wen_o,
    input mips_pkg::reg_addr_t              debug_wb_rf_wnum_o,
    input mips_pkg::word_t                  debug_wb_rf_wdata_o
);

    // byte strobes always move together
    wen_uniform: assert property (@(posedge cpu_clk_50M) disable iff (rst_i)
        (debug_wb_rf_wen_o == '0) || (debug_wb_rf_wen_o == '1))
        else $error("debug write strobe has mixed bits: %b", debug_wb_rf_wen_o);

    wnum_nonzero: assert property (@(posedge cpu_clk_50M) disable iff (rst_i)
        (debug_wb_rf_wen_o != '0) |-> (debug_wb_rf_wnum_o != '0))
        else $error("debug write enabled towards register 0");

    outputs_cleared: assert property (@(posedge cpu_clk_50M)
        rst_i |=> (debug_wb_pc_o == '0) && (debug_wb_rf_wen_o == '0) &&
                  (debug_wb_rf_wnum_o == '0) && (debug_wb_rf_wdata_o == '0))
        else $error("debug outputs not cleared by reset");

endmodule

bind mini_mips_core mini_mips_core_sva u_mini_mips_core_sva (
    .cpu_clk_50M        (cpu_clk_50M),
    .rst_i              (rst_i),
    .debug_wb_pc_o      (debug_wb_pc_o),
    .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
    .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
);

//--- test/tb_mini_mips_core.sv
`timescale 1ns/100ps

module tb_mini_mips_core;

    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic [31:0] due;
        logic        wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        logic [31:0] pc;
    } wb_exp_t;

    logic        cpu_clk_50M = 1'b0;
    logic        rst_i = 1'b1;
    logic        inst_valid_i = 1'b0;
    logic [31:0] inst_i = '0;
    logic [31:0] inst_pc_i = '0;
    logic [31:0] debug_wb_pc_o;
    logic [3:0]  debug_wb_rf_wen_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    logic [31:0] cyc = '0;
    logic [31:0] pc_next = 32'hbfc0_0000;
    logic [31:0] gpr [32];
    logic [31:0] hi = '0;
    logic [31:0] lo = '0;
    int          checks = 0;
    int          errors = 0;
    string       test_name = "reset_state";
    wb_exp_t     exp_q [$];
    string       name_q [$];
    wb_exp_t     cur;
    string       cur_name;

    mini_mips_core u_mini_mips_core (
        .cpu_clk_50M        (cpu_clk_50M),
        .rst_i              (rst_i),
        .inst_valid_i       (inst_valid_i),
        .inst_i             (inst_i),
        .inst_pc_i          (inst_pc_i),
        .debug_wb_pc_o      (debug_wb_pc_o),
        .debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
    );

    always #4 cpu_clk_50M = ~cpu_clk_50M;

    always @(posedge cpu_clk_50M) begin
        cyc <= cyc + 32'd1;
        if (cyc == TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input string field,
                             input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        assert (actv === expv) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", name, field, expv, actv);
        end
    endtask

    // writeback shows up three edges after the issuing edge
    always @(negedge cpu_clk_50M) begin
        if (!rst_i) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                cur = exp_q.pop_front();
                cur_name = name_q.pop_front();
                check_val(cur_name, "pc", cur.pc, debug_wb_pc_o);
                check_val(cur_name, "wen", {28'b0, {4{cur.wen}}}, {28'b0, debug_wb_rf_wen_o});
                if (cur.wen) begin
                    check_val(cur_name, "wnum", {27'b0, cur.wnum}, {27'b0, debug_wb_rf_wnum_o});
                    check_val(cur_name, "wdata", cur.wdata, debug_wb_rf_wdata_o);
                end
            end else begin
                checks++;
                assert (debug_wb_rf_wen_o == 4'b0000) else begin
                    errors++;
                    $display("register write seen at cycle %0d with no instruction due", cyc);
                end
            end
        end
    end

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sh,
                                           input logic [5:0] fn);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // reference model, updates gpr and hi/lo in program order
    task automatic predict(input logic [31:0] inst, output logic wen,
                           output logic [4:0] wnum, output logic [31:0] wdata);
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [63:0] uprod;
        longint      sprod;
        a = gpr[inst[25:21]];
        b = gpr[inst[20:16]];
        imm = inst[15:0];
        uprod = {32'b0, a} * {32'b0, b};
        sprod = longint'($signed(a)) * longint'($signed(b));
        wen = 1'b1;
        wnum = inst[20:16];
        wdata = '0;
        if (inst[31:26] == mips_pkg::OP_SPECIAL) begin
            wnum = inst[15:11];
            case (inst[5:0])
                mips_pkg::FN_ADDU:  wdata = a + b;
                mips_pkg::FN_SUBU:  wdata = a - b;
                mips_pkg::FN_AND:   wdata = a & b;
                mips_pkg::FN_OR:    wdata = a | b;
                mips_pkg::FN_XOR:   wdata = a ^ b;
                mips_pkg::FN_SLT:   wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                mips_pkg::FN_SLL:   wdata = b << inst[10:6];
                mips_pkg::FN_MFHI:  wdata = hi;
                mips_pkg::FN_MFLO:  wdata = lo;
                mips_pkg::FN_MULT: begin
                    {hi, lo} = sprod;
                    wen = 1'b0;
                end
                mips_pkg::FN_MULTU: begin
                    {hi, lo} = uprod;
                    wen = 1'b0;
                end
                mips_pkg::FN_MTHI: begin
                    hi = a;
                    wen = 1'b0;
                end
                mips_pkg::FN_MTLO: begin
                    lo = a;
                    wen = 1'b0;
                end
                default:            wen = 1'b0;
            endcase
        end else begin
            case (inst[31:26])
                mips_pkg::OP_ADDIU: wdata = a + {{16{imm[15]}}, imm};
                mips_pkg::OP_ORI:   wdata = a | {16'h0000, imm};
                mips_pkg::OP_LUI:   wdata = {imm, 16'h0000};
                default:            wen = 1'b0;
            endcase
        end
        if (wnum == 5'd0) begin
            wen = 1'b0;
        end
        if (wen) begin
            gpr[wnum] = wdata;
        end
    endtask

    task automatic issue(input logic [31:0] inst);
        wb_exp_t e;
        @(posedge cpu_clk_50M);
        #1;
        inst_valid_i = 1'b1;
        inst_i = inst;
        inst_pc_i = pc_next;
        e.due = cyc + 32'd3;
        e.pc = pc_next;
        predict(inst, e.wen, e.wnum, e.wdata);
        exp_q.push_back(e);
        name_q.push_back(test_name);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge cpu_clk_50M);
            #1;
            inst_valid_i = 1'b0;
        end
    endtask

    task automatic reset_state_test();
        test_name = "reset_state";
        repeat (3) begin
            @(negedge cpu_clk_50M);
            check_val(test_name, "wen", 32'd0, {28'b0, debug_wb_rf_wen_o});
            check_val(test_name, "pc", 32'd0, debug_wb_pc_o);
            check_val(test_name, "wdata", 32'd0, debug_wb_rf_wdata_o);
        end
    endtask

    task automatic immediates_test();
        test_name = "immediates";
        issue(i_type(mips_pkg::OP_ORI, 5'd0, 5'd1, 16'h1234));
        idle(2);
        issue(i_type(mips_pkg::OP_LUI, 5'd0, 5'd2, 16'habcd));
        idle(2);
        issue(i_type(mips_pkg::OP_ADDIU, 5'd1, 5'd3, 16'hfffb));
        idle(2);
        issue(i_type(mips_pkg::OP_ADDIU, 5'd2, 5'd4, 16'h7fff));
        idle(4);
    endtask

    // sources one, two and three back cover the alu result, wb and write-through
    task automatic dependent_chain_test();
        test_name = "dependent_chain";
        issue(i_type(mips_pkg::OP_ORI, 5'd0, 5'd5, 16'h00f0));
        issue(i_type(mips_pkg::OP_ORI, 5'd0, 5'd6, 16'h0f0f));
        issue(r_type(5'd5, 5'd6, 5'd7, 5'd0, mips_pkg::FN_ADDU));
        issue(r_type(5'd7, 5'd5, 5'd8, 5'd0, mips_pkg::FN_SUBU));
        issue(r_type(5'd8, 5'd7, 5'd9, 5'd0, mips_pkg::FN_AND));
        issue(r_type(5'd9, 5'd7, 5'd10, 5'd0, mips_pkg::FN_OR));
        issue(r_type(5'd10, 5'd8, 5'd11, 5'd0, mips_pkg::FN_XOR));
        issue(r_type(5'd0, 5'd11, 5'd13, 5'd0, mips_pkg::FN_SUBU));
        issue(r_type(5'd13, 5'd10, 5'd12, 5'd0, mips_pkg::FN_SLT));
        issue(r_type(5'd0, 5'd12, 5'd14, 5'd5, mips_pkg::FN_SLL));
        issue(r_type(5'd14, 5'd13, 5'd14, 5'd0, mips_pkg::FN_ADDU));
        idle(4);
    endtask

    task automatic hilo_test();
        test_name = "hilo";
        issue(i_type(mips_pkg::OP_ADDIU, 5'd0, 5'd15, 16'hfff9));
        issue(i_type(mips_pkg::OP_LUI, 5'd0, 5'd16, 16'hfedc));
        issue(i_type(mips_pkg::OP_ORI, 5'd16, 5'd16, 16'hba98));
        issue(r_type(5'd15, 5'd16, 5'd0, 5'd0, mips_pkg::FN_MULT));
        issue(r_type(5'd0, 5'd0, 5'd17, 5'd0, mips_pkg::FN_MFHI));
        issue(r_type(5'd0, 5'd0, 5'd18, 5'd0, mips_pkg::FN_MFLO));
        issue(r_type(5'd15, 5'd16, 5'd0, 5'd0, mips_pkg::FN_MULTU));
        issue(r_type(5'd0, 5'd0, 5'd19, 5'd0, mips_pkg::FN_MFHI));
        issue(r_type(5'd0, 5'd0, 5'd20, 5'd0, mips_pkg::FN_MFLO));
        issue(r_type(5'd5, 5'd0, 5'd0, 5'd0, mips_pkg::FN_MTHI));
        issue(r_type(5'd6, 5'd0, 5'd0, 5'd0, mips_pkg::FN_MTLO));
        issue(r_type(5'd0, 5'd0, 5'd21, 5'd0, mips_pkg::FN_MFHI));
        issue(r_type(5'd0, 5'd0, 5'd22, 5'd0, mips_pkg::FN_MFLO));
        // reads the hi/lo unit result one back
        issue(r_type(5'd21, 5'd22, 5'd25, 5'd0, mips_pkg::FN_ADDU));
        idle(4);
    endtask

    task automatic reg_zero_test();
        test_name = "reg_zero_unknown";
        issue(i_type(mips_pkg::OP_ADDIU, 5'd5, 5'd0, 16'h0007));
        issue(r_type(5'd5, 5'd6, 5'd0, 5'd0, mips_pkg::FN_OR));
        issue(r_type(5'd0, 5'd5, 5'd23, 5'd0, mips_pkg::FN_ADDU));
        // a load and a jr, neither is supported
        issue(i_type(6'b100011, 5'd5, 5'd6, 16'h0004));
        issue(r_type(5'd5, 5'd0, 5'd7, 5'd0, 6'b001000));
        issue(r_type(5'd6, 5'd7, 5'd24, 5'd0, mips_pkg::FN_ADDU));
        idle(4);
    endtask

    function automatic logic [5:0] alu_funct(input logic [2:0] k);
        case (k)
            3'd0:    return mips_pkg::FN_ADDU;
            3'd1:    return mips_pkg::FN_SUBU;
            3'd2:    return mips_pkg::FN_AND;
            3'd3:    return mips_pkg::FN_OR;
            3'd4:    return mips_pkg::FN_XOR;
            3'd5:    return mips_pkg::FN_SLT;
            default: return mips_pkg::FN_ADDU;
        endcase
    endfunction

    task automatic random_test();
        logic [31:0] r;
        logic [31:0] r2;
        test_name = "random";
        for (int i = 0; i < 200; i++) begin
            r = $urandom();
            r2 = $urandom();
            case (r[23:20])
                4'd7:  issue(r_type(5'd0, r[9:5], r[14:10], r[19:15], mips_pkg::FN_SLL));
                4'd8:  issue(i_type(mips_pkg::OP_ADDIU, r[4:0], r[9:5], r2[15:0]));
                4'd9:  issue(i_type(mips_pkg::OP_ORI, r[4:0], r[9:5], r2[15:0]));
                4'd10: issue(i_type(mips_pkg::OP_LUI, 5'd0, r[9:5], r2[15:0]));
                4'd11: issue(r_type(r[4:0], r[9:5], 5'd0, 5'd0, mips_pkg::FN_MULT));
                4'd12: issue(r_type(r[4:0], r[9:5], 5'd0, 5'd0, mips_pkg::FN_MULTU));
                4'd13: issue(r_type(5'd0, 5'd0, r[14:10], 5'd0, mips_pkg::FN_MFHI));
                4'd14: issue(r_type(5'd0, 5'd0, r[14:10], 5'd0, mips_pkg::FN_MFLO));
                4'd15: issue(r_type(r[4:0], 5'd0, 5'd0, 5'd0,
                                    r[24] ? mips_pkg::FN_MTHI : mips_pkg::FN_MTLO));
                default: issue(r_type(r[4:0], r[9:5], r[14:10], 5'd0, alu_funct(r[22:20])));
            endcase
        end
        idle(4);
    endtask

    initial begin
        for (int i = 0; i < 32; i++) begin
            gpr[i] = '0;
        end
        void'($urandom(52));
        repeat (4) @(posedge cpu_clk_50M);
        #1;
        rst_i = 1'b0;
        reset_state_test();
        immediates_test();
        dependent_chain_test();
        hilo_test();
        reg_zero_test();
        random_test();
        idle(2);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
